//--- common/backend_pkg.sv
`default_nettype none

package backend_pkg;

    typedef logic [31:0] bus32_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  dmem_addr_t;

    localparam int DMEM_WORDS = 64;

    // stage order matches the pause and flush vectors
    localparam int PIPE_WIDTH     = 5;
    localparam int STAGE_DECODE   = 0;
    localparam int STAGE_DISPATCH = 1;
    localparam int STAGE_EXECUTE  = 2;
    localparam int STAGE_MEM      = 3;
    localparam int STAGE_WB       = 4;

    // 3R type, bits 31:15
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_SLT   = 17'h00024;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;
    // 2RI12 type, bits 31:22
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
    localparam logic [9:0]  OPC_LD_W   = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W   = 10'h0a6;
    // 2RI16 type, bits 31:26
    localparam logic [5:0]  OPC_BEQ = 6'h16;
    localparam logic [5:0]  OPC_BNE = 6'h17;
    // bits 31:10, with rj zero
    localparam logic [21:0] OPC_RDCNTVL_W = 22'h000018;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_NONE
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    typedef struct packed {
        logic      valid;
        bus32_t    pc;
        alu_op_t   alu_op;
        mem_op_t   mem_op;
        logic      is_branch;
        logic      branch_ne;
        logic      is_cnt;
        reg_addr_t rj;
        reg_addr_t rk_or_rd;
        reg_addr_t rd;
        logic      reg_we;
        bus32_t    imm;
        logic      use_imm;
    } id_dispatch_t;

    typedef struct packed {
        id_dispatch_t op;
        bus32_t       src1;
        bus32_t       src2;
    } dispatch_ex_t;

    typedef struct packed {
        logic      valid;
        bus32_t    pc;
        reg_addr_t rd;
        logic      reg_we;
        bus32_t    result;
        mem_op_t   mem_op;
        bus32_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        bus32_t    pc;
        reg_addr_t rd;
        logic      reg_we;
        bus32_t    wdata;
    } mem_wb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        bus32_t    data;
        logic      is_load;
    } push_forward_t;

    typedef struct packed {
        logic      valid;
        bus32_t    pc;
        reg_addr_t rd;
        logic      we;
        bus32_t    wdata;
    } commit_t;

endpackage

`default_nettype wire

//--- decoder/decoder.sv
`default_nettype none

module decoder (
    input  wire logic                 clk,
    input  wire logic                 arst_n_i,
    input  wire logic                 flush_i,
    input  wire logic                 pause_i,
    input  wire logic                 inst_valid_i,
    input  wire backend_pkg::bus32_t  pc_i,
    input  wire backend_pkg::bus32_t  inst_i,
    output backend_pkg::id_dispatch_t dispatch_o
);
    import backend_pkg::*;

    id_dispatch_t dec;
    alu_op_t      reg_op;
    reg_addr_t    rd;
    reg_addr_t    rj;
    reg_addr_t    rk;
    bus32_t       si12;
    bus32_t       offs16;

    assign rd     = inst_i[4:0];
    assign rj     = inst_i[9:5];
    assign rk     = inst_i[14:10];
    assign si12   = {{20{inst_i[21]}}, inst_i[21:10]};
    assign offs16 = {{16{inst_i[25]}}, inst_i[25:10]};

    always_comb begin
        case (inst_i[31:15])
            OPC_ADD_W: reg_op = ALU_ADD;
            OPC_SUB_W: reg_op = ALU_SUB;
            OPC_AND:   reg_op = ALU_AND;
            OPC_OR:    reg_op = ALU_OR;
            OPC_XOR:   reg_op = ALU_XOR;
            OPC_SLT:   reg_op = ALU_SLT;
            default:   reg_op = ALU_NONE;
        endcase
    end

    // unused source indices stay r0, so they never forward or stall
    always_comb begin
        dec = '0;
        dec.valid = inst_valid_i;
        dec.pc = pc_i;
        dec.alu_op = ALU_NONE;
        dec.mem_op = MEM_NONE;
        if (reg_op != ALU_NONE) begin
            dec.alu_op = reg_op;
            dec.rj = rj;
            dec.rk_or_rd = rk;
            dec.rd = rd;
        end else if (inst_i[31:22] == OPC_ADDI_W) begin
            dec.alu_op = ALU_ADD;
            dec.rj = rj;
            dec.rd = rd;
            dec.imm = si12;
            dec.use_imm = 1'b1;
        end else if (inst_i[31:22] == OPC_LD_W) begin
            dec.mem_op = MEM_LOAD;
            dec.rj = rj;
            dec.rd = rd;
            dec.imm = si12;
            dec.use_imm = 1'b1;
        end else if (inst_i[31:22] == OPC_ST_W) begin
            dec.mem_op = MEM_STORE;
            dec.rj = rj;
            dec.rk_or_rd = rd;
            dec.imm = si12;
        end else if (inst_i[31:26] == OPC_BEQ || inst_i[31:26] == OPC_BNE) begin
            dec.is_branch = 1'b1;
            dec.branch_ne = (inst_i[31:26] == OPC_BNE);
            dec.rj = rj;
            dec.rk_or_rd = rd;
            dec.imm = offs16;
        end else if (inst_i[31:10] == OPC_RDCNTVL_W && rj == '0) begin
            dec.is_cnt = 1'b1;
            dec.rd = rd;
        end
        // writes to r0 are dropped here
        dec.reg_we = (dec.rd != '0);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dispatch_o <= '0;
        end else if (flush_i) begin
            dispatch_o.valid <= 1'b0;
        end else if (!pause_i) begin
            dispatch_o <= dec;
        end
    end

endmodule

`default_nettype wire

//--- logic/dispatch.sv
`default_nettype none

module dispatch (
    input  wire logic                      clk,
    input  wire logic                      arst_n_i,
    input  wire logic                      flush_i,
    input  wire logic                      pause_i,
    input  wire backend_pkg::id_dispatch_t dispatch_i,
    input  wire backend_pkg::push_forward_t ex_pf_i,
    input  wire backend_pkg::push_forward_t mem_pf_i,
    input  wire backend_pkg::push_forward_t wb_pf_i,
    output backend_pkg::reg_addr_t         rf_raddr1_o,
    output backend_pkg::reg_addr_t         rf_raddr2_o,
    input  wire backend_pkg::bus32_t       rf_rdata1_i,
    input  wire backend_pkg::bus32_t       rf_rdata2_i,
    output logic                           load_use_o,
    output backend_pkg::dispatch_ex_t      ex_o
);
    import backend_pkg::*;

    bus32_t src1;
    bus32_t src2;
    bus32_t src2_reg;

    // youngest producer wins
    function automatic bus32_t resolve(input reg_addr_t addr, input bus32_t rf_data,
                                       input push_forward_t ex_pf,
                                       input push_forward_t mem_pf,
                                       input push_forward_t wb_pf);
        bus32_t data;
        data = rf_data;
        if (addr != '0) begin
            if (ex_pf.valid && ex_pf.rd == addr) begin
                data = ex_pf.data;
            end else if (mem_pf.valid && mem_pf.rd == addr) begin
                data = mem_pf.data;
            end else if (wb_pf.valid && wb_pf.rd == addr) begin
                data = wb_pf.data;
            end
        end
        return data;
    endfunction

    assign rf_raddr1_o = dispatch_i.rj;
    assign rf_raddr2_o = dispatch_i.rk_or_rd;

    assign src1     = resolve(dispatch_i.rj, rf_rdata1_i, ex_pf_i, mem_pf_i, wb_pf_i);
    assign src2_reg = resolve(dispatch_i.rk_or_rd, rf_rdata2_i, ex_pf_i, mem_pf_i, wb_pf_i);
    assign src2     = dispatch_i.use_imm ? dispatch_i.imm : src2_reg;

    // load data only exists one stage later
    assign load_use_o = dispatch_i.valid && ex_pf_i.valid && ex_pf_i.is_load &&
                        (ex_pf_i.rd == dispatch_i.rj || ex_pf_i.rd == dispatch_i.rk_or_rd);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_o <= '0;
        end else if (flush_i) begin
            ex_o.op.valid <= 1'b0;
        end else if (!pause_i) begin
            ex_o.op   <= dispatch_i;
            ex_o.src1 <= src1;
            ex_o.src2 <= src2;
        end
    end

endmodule

`default_nettype wire

//--- logic/execute.sv
`default_nettype none

module execute (
    input  wire logic                      clk,
    input  wire logic                      arst_n_i,
    input  wire logic                      flush_i,
    input  wire logic                      pause_i,
    input  wire backend_pkg::dispatch_ex_t ex_i,
    input  wire backend_pkg::bus32_t       cnt_i,
    output backend_pkg::push_forward_t     ex_pf_o,
    output logic                           branch_flush_o,
    output backend_pkg::bus32_t            branch_target_o,
    output backend_pkg::ex_mem_t           mem_o
);
    import backend_pkg::*;

    bus32_t  alu_res;
    bus32_t  addr;
    bus32_t  result;
    ex_mem_t mem_d;

    always_comb begin
        case (ex_i.op.alu_op)
            ALU_ADD: alu_res = ex_i.src1 + ex_i.src2;
            ALU_SUB: alu_res = ex_i.src1 - ex_i.src2;
            ALU_AND: alu_res = ex_i.src1 & ex_i.src2;
            ALU_OR:  alu_res = ex_i.src1 | ex_i.src2;
            ALU_XOR: alu_res = ex_i.src1 ^ ex_i.src2;
            ALU_SLT: alu_res = {31'b0, $signed(ex_i.src1) < $signed(ex_i.src2)};
            default: alu_res = '0;
        endcase
    end

    assign addr = ex_i.src1 + ex_i.op.imm;

    always_comb begin
        if (ex_i.op.is_cnt) begin
            result = cnt_i;
        end else if (ex_i.op.mem_op != MEM_NONE) begin
            result = addr;
        end else begin
            result = alu_res;
        end
    end

    // not-taken is the only prediction, so any taken branch redirects
    assign branch_flush_o  = ex_i.op.valid && ex_i.op.is_branch &&
                             ((ex_i.src1 == ex_i.src2) != ex_i.op.branch_ne);
    assign branch_target_o = ex_i.op.pc + {ex_i.op.imm[29:0], 2'b00};

    assign ex_pf_o = '{
        valid:   ex_i.op.valid && ex_i.op.reg_we,
        rd:      ex_i.op.rd,
        data:    result,
        is_load: ex_i.op.mem_op == MEM_LOAD
    };

    always_comb begin
        mem_d.valid      = ex_i.op.valid;
        mem_d.pc         = ex_i.op.pc;
        mem_d.rd         = ex_i.op.rd;
        mem_d.reg_we     = ex_i.op.reg_we;
        mem_d.result     = result;
        mem_d.mem_op     = ex_i.op.mem_op;
        mem_d.store_data = ex_i.src2;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_o <= '0;
        end else if (flush_i) begin
            mem_o.valid <= 1'b0;
        end else if (!pause_i) begin
            mem_o <= mem_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/mem.sv
`default_nettype none

module mem (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,
    input  wire logic                   flush_i,
    input  wire logic                   pause_i,
    input  wire backend_pkg::ex_mem_t   mem_i,
    output backend_pkg::push_forward_t  mem_pf_o,
    output backend_pkg::mem_wb_t        wb_o
);
    import backend_pkg::*;

    bus32_t     dmem [DMEM_WORDS];
    dmem_addr_t word_addr;
    bus32_t     load_data;
    mem_wb_t    wb_d;

    assign word_addr = mem_i.result[7:2];
    assign load_data = dmem[word_addr];

    // scratchpad starts cleared
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_i.valid && mem_i.mem_op == MEM_STORE && !pause_i && !flush_i) begin
            dmem[word_addr] <= mem_i.store_data;
        end
    end

    assign wb_d = '{
        valid:  mem_i.valid,
        pc:     mem_i.pc,
        rd:     mem_i.rd,
        reg_we: mem_i.reg_we,
        wdata:  (mem_i.mem_op == MEM_LOAD) ? load_data : mem_i.result
    };

    assign mem_pf_o = '{
        valid:   mem_i.valid && mem_i.reg_we,
        rd:      mem_i.rd,
        data:    wb_d.wdata,
        is_load: mem_i.mem_op == MEM_LOAD
    };

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_o <= '0;
        end else if (flush_i) begin
            wb_o.valid <= 1'b0;
        end else if (!pause_i) begin
            wb_o <= wb_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/wb.sv
`default_nettype none

module wb (
    input  wire logic                  clk,
    input  wire logic                  arst_n_i,
    input  wire logic                  flush_i,
    input  wire logic                  pause_i,
    input  wire backend_pkg::mem_wb_t  wb_i,
    output backend_pkg::push_forward_t wb_pf_o,
    output logic                       rf_we_o,
    output backend_pkg::reg_addr_t     rf_waddr_o,
    output backend_pkg::bus32_t        rf_wdata_o,
    output backend_pkg::commit_t       commit_o
);
    import backend_pkg::*;

    mem_wb_t wb_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_q <= '0;
        end else if (flush_i) begin
            wb_q.valid <= 1'b0;
        end else if (!pause_i) begin
            wb_q <= wb_i;
        end
    end

    assign rf_we_o    = wb_q.valid && wb_q.reg_we;
    assign rf_waddr_o = wb_q.rd;
    assign rf_wdata_o = wb_q.wdata;

    // the op entering wb forwards here, the one in wb_q goes through regfile write-through
    assign wb_pf_o = '{
        valid:   wb_i.valid && wb_i.reg_we,
        rd:      wb_i.rd,
        data:    wb_i.wdata,
        is_load: 1'b0
    };

    // non-writing ops retire with zero data
    assign commit_o = '{
        valid: wb_q.valid,
        pc:    wb_q.pc,
        rd:    wb_q.rd,
        we:    rf_we_o,
        wdata: rf_we_o ? wb_q.wdata : '0
    };

endmodule

`default_nettype wire

//--- logic/ctrl.sv
`default_nettype none

module ctrl (
    input  wire logic                                clk,
    input  wire logic                                arst_n_i,
    input  wire logic                                load_use_i,
    input  wire logic                                pause_buffer_i,
    input  wire logic                                branch_flush_i,
    input  wire backend_pkg::bus32_t                 branch_target_i,
    output logic [backend_pkg::PIPE_WIDTH-1:0]       pause_o,
    output logic [backend_pkg::PIPE_WIDTH-1:0]       flush_o,
    output logic                                     send_inst_en_o,
    output logic                                     redirect_o,
    output backend_pkg::bus32_t                      new_pc_o,
    output backend_pkg::bus32_t                      cnt_o
);
    import backend_pkg::*;

    bus32_t cnt_q;

    always_comb begin
        pause_o = '0;
        pause_o[STAGE_DECODE]   = load_use_i || pause_buffer_i;
        pause_o[STAGE_DISPATCH] = load_use_i;
        // a paused stage feeding a running one emits a bubble
        flush_o = '0;
        for (int i = 0; i < PIPE_WIDTH - 1; i++) begin
            flush_o[i] = pause_o[i] && !pause_o[i+1];
        end
        flush_o[STAGE_DECODE]   = flush_o[STAGE_DECODE] || branch_flush_i;
        flush_o[STAGE_DISPATCH] = flush_o[STAGE_DISPATCH] || branch_flush_i;
    end

    assign send_inst_en_o = !pause_o[STAGE_DECODE] && !branch_flush_i;
    assign redirect_o     = branch_flush_i;
    assign new_pc_o       = branch_target_i;

    // stable counter
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 32'd1;
        end
    end

    assign cnt_o = cnt_q;

endmodule

`default_nettype wire

//--- logic/regfile.sv
`default_nettype none

module regfile (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,
    input  wire backend_pkg::reg_addr_t raddr1_i,
    input  wire backend_pkg::reg_addr_t raddr2_i,
    output backend_pkg::bus32_t         rdata1_o,
    output backend_pkg::bus32_t         rdata2_o,
    input  wire logic                   we_i,
    input  wire backend_pkg::reg_addr_t waddr_i,
    input  wire backend_pkg::bus32_t    wdata_i
);
    import backend_pkg::*;

    bus32_t regs [32];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through on a same-cycle hit
    function automatic bus32_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

`default_nettype wire

//--- logic/backend_top.sv
`default_nettype none

module backend_top (
    input  wire logic                clk,
    input  wire logic                arst_n_i,
    input  wire logic                inst_valid_i,
    input  wire backend_pkg::bus32_t pc_i,
    input  wire backend_pkg::bus32_t inst_i,
    input  wire logic                pause_buffer_i,
    output logic                     send_inst_en_o,
    output logic                     redirect_o,
    output backend_pkg::bus32_t      new_pc_o,
    output backend_pkg::commit_t     commit_o
);
    import backend_pkg::*;

    // ctrl
    logic [PIPE_WIDTH-1:0] pause;
    logic [PIPE_WIDTH-1:0] flush;
    logic                  load_use;
    logic                  branch_flush;
    bus32_t                branch_target;
    bus32_t                cnt;

    // stage registers
    id_dispatch_t id_q;
    dispatch_ex_t ex_q;
    ex_mem_t      mem_q;
    mem_wb_t      wb_q;

    push_forward_t ex_pf;
    push_forward_t mem_pf;
    push_forward_t wb_pf;

    // regfile
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    bus32_t    rf_rdata1;
    bus32_t    rf_rdata2;
    logic      rf_we;
    reg_addr_t rf_waddr;
    bus32_t    rf_wdata;

    decoder u_decoder (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush[STAGE_DECODE]),
        .pause_i      (pause[STAGE_DECODE]),
        .inst_valid_i (inst_valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .dispatch_o   (id_q)
    );

    dispatch u_dispatch (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush[STAGE_DISPATCH]),
        .pause_i     (pause[STAGE_DISPATCH]),
        .dispatch_i  (id_q),
        .ex_pf_i     (ex_pf),
        .mem_pf_i    (mem_pf),
        .wb_pf_i     (wb_pf),
        .rf_raddr1_o (rf_raddr1),
        .rf_raddr2_o (rf_raddr2),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .load_use_o  (load_use),
        .ex_o        (ex_q)
    );

    execute u_execute (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush[STAGE_EXECUTE]),
        .pause_i         (pause[STAGE_EXECUTE]),
        .ex_i            (ex_q),
        .cnt_i           (cnt),
        .ex_pf_o         (ex_pf),
        .branch_flush_o  (branch_flush),
        .branch_target_o (branch_target),
        .mem_o           (mem_q)
    );

    mem u_mem (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush[STAGE_MEM]),
        .pause_i  (pause[STAGE_MEM]),
        .mem_i    (mem_q),
        .mem_pf_o (mem_pf),
        .wb_o     (wb_q)
    );

    wb u_wb (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush[STAGE_WB]),
        .pause_i    (pause[STAGE_WB]),
        .wb_i       (wb_q),
        .wb_pf_o    (wb_pf),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .commit_o   (commit_o)
    );

    ctrl u_ctrl (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .load_use_i      (load_use),
        .pause_buffer_i  (pause_buffer_i),
        .branch_flush_i  (branch_flush),
        .branch_target_i (branch_target),
        .pause_o         (pause),
        .flush_o         (flush),
        .send_inst_en_o  (send_inst_en_o),
        .redirect_o      (redirect_o),
        .new_pc_o        (new_pc_o),
        .cnt_o           (cnt)
    );

    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

endmodule

`default_nettype wire

//--- test/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int N_INST = 300;

// encodings, same values as the LoongArch manual
localparam logic [16:0] ENC_ADD_W = 17'h00020;
localparam logic [16:0] ENC_SUB_W = 17'h00022;
localparam logic [16:0] ENC_SLT   = 17'h00024;
localparam logic [16:0] ENC_AND   = 17'h00029;
localparam logic [16:0] ENC_OR    = 17'h0002a;
localparam logic [16:0] ENC_XOR   = 17'h0002b;
localparam logic [9:0]  ENC_ADDI_W = 10'h00a;
localparam logic [9:0]  ENC_LD_W   = 10'h0a2;
localparam logic [9:0]  ENC_ST_W   = 10'h0a6;
localparam logic [5:0]  ENC_BEQ = 6'h16;
localparam logic [5:0]  ENC_BNE = 6'h17;
localparam logic [21:0] ENC_RDCNTVL_W = 22'h000018;

logic [31:0] lfsr_state = 32'h9b09;
logic [31:0] prog [N_INST];
logic [31:0] model_rf [32];
logic [31:0] model_mem [64];
logic [31:0] model_pc;

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
    end
    return v;
endfunction

function automatic logic is_cnt_read(input logic [31:0] inst);
    return inst[31:10] == ENC_RDCNTVL_W && inst[9:5] == 5'd0;
endfunction

// registers r0..r7 only so hazards show up often
task automatic build_program();
    logic [31:0] sel;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [15:0] off;
    logic [11:0] imm;
    for (int i = 0; i < N_INST; i++) begin
        sel = take_bits(4);
        rd  = 5'(take_bits(3));
        rj  = 5'(take_bits(3));
        rk  = 5'(take_bits(3));
        imm = 12'(take_bits(12));
        off = 16'(2 + take_bits(3));
        if (int'(off) > N_INST - i) begin
            off = 16'(N_INST - i);
        end
        case (sel[3:0])
            4'd0: prog[i] = {ENC_ADD_W, rk, rj, rd};
            4'd1: prog[i] = {ENC_SUB_W, rk, rj, rd};
            4'd2: prog[i] = {ENC_AND, rk, rj, rd};
            4'd3: prog[i] = {ENC_OR, rk, rj, rd};
            4'd4: prog[i] = {ENC_XOR, rk, rj, rd};
            4'd5: prog[i] = {ENC_SLT, rk, rj, rd};
            4'd6, 4'd7, 4'd8: prog[i] = {ENC_ADDI_W, imm, rj, rd};
            4'd9, 4'd10: prog[i] = {ENC_LD_W, 4'd0, imm[5:0], 2'b00, 5'd0, rd};
            4'd11: prog[i] = {ENC_ST_W, 4'd0, imm[5:0], 2'b00, 5'd0, rd};
            4'd12: prog[i] = {ENC_BEQ, off, rj, rd};
            4'd13: prog[i] = {ENC_BNE, off, rj, rd};
            4'd14: prog[i] = {ENC_RDCNTVL_W, 5'd0, (rd == 5'd0) ? 5'd1 : rd};
            default: prog[i] = 32'hffff_ffff;
        endcase
    end
    for (int i = 0; i < 32; i++) begin
        model_rf[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        model_mem[i] = '0;
    end
    model_pc = '0;
endtask

// retires one instruction with cnt_val as the value rdcntvl.w reads
task automatic model_step(input logic [31:0] cnt_val, output logic we,
                          output logic [4:0] rd_o, output logic [31:0] wdata,
                          output logic taken);
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    logic [31:0] si12;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic        wr;
    inst    = prog[int'(model_pc >> 2)];
    a       = model_rf[inst[9:5]];
    b       = model_rf[inst[14:10]];
    d       = model_rf[inst[4:0]];
    si12    = {{20{inst[21]}}, inst[21:10]};
    next_pc = model_pc + 32'd4;
    res     = '0;
    wr      = 1'b1;
    taken   = 1'b0;
    if (inst[31:15] == ENC_ADD_W) res = a + b;
    else if (inst[31:15] == ENC_SUB_W) res = a - b;
    else if (inst[31:15] == ENC_AND) res = a & b;
    else if (inst[31:15] == ENC_OR) res = a | b;
    else if (inst[31:15] == ENC_XOR) res = a ^ b;
    else if (inst[31:15] == ENC_SLT) res = {31'd0, $signed(a) < $signed(b)};
    else if (inst[31:22] == ENC_ADDI_W) res = a + si12;
    else if (inst[31:22] == ENC_LD_W) res = model_mem[(a + si12) >> 2 & 32'h3f];
    else if (inst[31:22] == ENC_ST_W) begin
        model_mem[(a + si12) >> 2 & 32'h3f] = d;
        wr = 1'b0;
    end else if (inst[31:26] == ENC_BEQ || inst[31:26] == ENC_BNE) begin
        if ((a == d) != (inst[31:26] == ENC_BNE)) begin
            next_pc = model_pc + {{14{inst[25]}}, inst[25:10], 2'b00};
            taken   = 1'b1;
        end
        wr = 1'b0;
    end else if (is_cnt_read(inst)) res = cnt_val;
    else wr = 1'b0;
    we    = wr && inst[4:0] != 5'd0;
    rd_o  = we ? inst[4:0] : 5'd0;
    wdata = we ? res : '0;
    if (we) begin
        model_rf[inst[4:0]] = res;
    end
    model_pc = next_pc;
endtask

`endif

//--- test/tb_backend.sv
`default_nettype none

module tb_backend;
    import backend_pkg::*;

    logic    clk = 1'b0;
    logic    arst_n_i;
    logic    inst_valid_i;
    bus32_t  pc_i;
    bus32_t  inst_i;
    logic    pause_buffer_i;
    logic    send_inst_en_o;
    logic    redirect_o;
    bus32_t  new_pc_o;
    commit_t commit_o;

    int     errors = 0;
    int     commits = 0;
    logic   done = 1'b0;
    bus32_t fetch_pc;
    bus32_t last_cnt;
    logic   cnt_seen = 1'b0;
    bus32_t cycles = '0;
    bus32_t redirect_q [$];

    `include "tb_model.svh"

    always #2 clk = ~clk;

    backend_top dut_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .inst_valid_i   (inst_valid_i),
        .pc_i           (pc_i),
        .inst_i         (inst_i),
        .pause_buffer_i (pause_buffer_i),
        .send_inst_en_o (send_inst_en_o),
        .redirect_o     (redirect_o),
        .new_pc_o       (new_pc_o),
        .commit_o       (commit_o)
    );

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // fetch from the program and follow redirects
    always @(posedge clk) begin
        bus32_t next_pc;
        next_pc = fetch_pc;
        if (!arst_n_i) begin
            next_pc = '0;
        end else if (redirect_o) begin
            next_pc = new_pc_o;
        end else if (inst_valid_i && send_inst_en_o) begin
            next_pc = fetch_pc + 32'd4;
        end
        fetch_pc       <= next_pc;
        inst_valid_i   <= next_pc < 32'(N_INST * 4);
        pc_i           <= next_pc;
        inst_i         <= (next_pc < 32'(N_INST * 4)) ? prog[int'(next_pc >> 2)] : '0;
        pause_buffer_i <= take_bits(3) == 32'd0;
    end

    always @(posedge clk) begin
        logic        exp_we;
        logic [4:0]  exp_rd;
        bus32_t      exp_wdata;
        logic        exp_taken;
        if (arst_n_i) begin
            if (redirect_o) begin
                redirect_q.push_back(new_pc_o);
            end
            // no fetch is taken while the buffer stalls or a redirect is out
            if (pause_buffer_i || redirect_o) begin
                check_equal("accept level", {31'd0, send_inst_en_o}, 32'd0);
            end
            if (commit_o.valid) begin
                if (done) begin
                    errors++;
                    $display("an instruction at pc %h retired after the program ended",
                             commit_o.pc);
                end else begin
                    check_equal("commit pc", commit_o.pc, model_pc);
                    if (is_cnt_read(prog[int'(model_pc >> 2)]) && commit_o.we) begin
                        if (cnt_seen && commit_o.wdata <= last_cnt) begin
                            errors++;
                            $display("counter read %h did not increase over %h",
                                     commit_o.wdata, last_cnt);
                        end
                        cnt_seen = 1'b1;
                        last_cnt = commit_o.wdata;
                    end
                    // execute read the counter three edges before commit
                    model_step(cycles - 32'd3, exp_we, exp_rd, exp_wdata, exp_taken);
                    check_equal("commit we", {31'd0, commit_o.we}, {31'd0, exp_we});
                    check_equal("commit rd", {27'd0, commit_o.rd}, {27'd0, exp_rd});
                    check_equal("commit wdata", commit_o.wdata, exp_wdata);
                    if (exp_taken) begin
                        if (redirect_q.size() == 0) begin
                            errors++;
                            $display("taken branch at pc %h retired without a redirect",
                                     commit_o.pc);
                        end else begin
                            check_equal("redirect target", redirect_q.pop_front(), model_pc);
                        end
                    end
                    commits++;
                    if (model_pc >= 32'(N_INST * 4)) begin
                        done = 1'b1;
                    end
                end
            end
            cycles++;
        end
    end

    initial begin
        arst_n_i       = 1'b0;
        inst_valid_i   = 1'b0;
        pc_i           = '0;
        inst_i         = '0;
        pause_buffer_i = 1'b0;
        fetch_pc       = '0;
        build_program();
        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;
        wait (done);
        // catch stray commits after the end
        repeat (20) @(posedge clk);
        if (redirect_q.size() != 0) begin
            errors++;
            $display("%0d redirects came without a taken branch", redirect_q.size());
        end
        $display("commits %0d, errors %0d", commits, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #((20 * N_INST + 200) * 4);
        $display("watchdog expired before the program retired, %0d commits", commits);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+test
common/backend_pkg.sv
decoder/decoder.sv
logic/dispatch.sv
logic/execute.sv
logic/mem.sv
logic/wb.sv
logic/ctrl.sv
logic/regfile.sv
logic/backend_top.sv
test/tb_backend.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_backend
RTL_TOP   ?= backend_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
